// ==== dv/ts_capture_tb.sv ====
`timescale 1ns/1ps

module ts_capture_tb;
    import ts_pkg::*;

    localparam int CPU_TB   = 4;               // short microsecond for quick runs
    localparam int READ_LAT = 13;              // rd_req to ts_valid, serializer idle
    localparam int SER_LEN  = 9;               // pre_stb plus eight byte cycles
    localparam int TMO      = 200;             // cycles before a wait gives up

    logic              aclk;
    logic              rrst;
    logic              set_time;
    logic [SEC_W-1:0]  set_sec;
    logic [USEC_W-1:0] set_usec;
    logic              capture;
    logic              rd_req;
    logic [SEC_W-1:0]  ts_sec;
    logic [USEC_W-1:0] ts_usec;
    logic              ts_valid;
    logic              busy;

    // reference model
    logic [SEC_W-1:0]  base_sec;               // last loaded time
    logic [USEC_W-1:0] base_usec;
    longint            since_load;             // edges since the load edge
    int                ser_left;               // transfer cycles still running
    longint            tot_usec;               // scratch for the carry
    logic [SEC_W-1:0]  newest_sec;             // newest accepted snapshot
    logic [USEC_W-1:0] newest_usec;

    logic              req_seen;               // first rd_req issued
    logic [SEC_W-1:0]  got_sec;                // last read result
    logic [USEC_W-1:0] got_usec;
    logic [SEC_W-1:0]  keep_sec;               // snapshot held for comparison
    logic [USEC_W-1:0] keep_usec;

    ts_capture_top #(
        .CLK_PER_USEC (CPU_TB)
    ) ts_capture_top_i (
        .aclk     (aclk),
        .rrst     (rrst),
        .set_time (set_time),
        .set_sec  (set_sec),
        .set_usec (set_usec),
        .capture  (capture),
        .rd_req   (rd_req),
        .ts_sec   (ts_sec),
        .ts_usec  (ts_usec),
        .ts_valid (ts_valid),
        .busy     (busy)
    );

    always #2 aclk = ~aclk;                    // 4 ns period

    // counter value at an edge is the value left by the previous edge
    always @(posedge aclk) begin
        if (rrst) begin
            since_load <= 0;
            ser_left   <= 0;
            base_sec   <= '0;
            base_usec  <= '0;
        end else begin
            if (set_time) begin
                since_load <= 0;
                base_sec   <= set_sec;
                base_usec  <= set_usec;
            end else begin
                since_load <= since_load + 1;
            end
            if (capture && ser_left == 0) begin
                tot_usec    = longint'(base_usec) + since_load / CPU_TB;
                newest_sec  <= base_sec + SEC_W'(tot_usec / USEC_PER_SEC);   // carry
                newest_usec <= USEC_W'(tot_usec % USEC_PER_SEC);
                ser_left    <= SER_LEN;                                      // busy window
            end else if (ser_left != 0) begin
                ser_left <= ser_left - 1;                                    // late captures dropped
            end
        end
    end

    task automatic report_value_error(input string msg);
        $display("[FAIL] %0d ns %s", $time, msg);
        $display("TEST FAIL");
        $fatal(1, "stopping at the first wrong value");
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out after %0d cycles waiting for %s", TMO, what);
        $display("TEST FAIL");
        $fatal(1, "stopping on a timeout");
    endtask

    // ts_valid is a single-cycle strobe
    valid_one_cycle: assert property (@(posedge aclk) disable iff (rrst) ts_valid |=> !ts_valid)
        else report_value_error("ts_valid high for more than one cycle");

    valid_in_busy: assert property (@(posedge aclk) disable iff (rrst) ts_valid |-> busy)
        else report_value_error("ts_valid outside the busy window");

    quiet_before_req: assert property (@(posedge aclk) disable iff (rrst)
        !req_seen |-> (!busy && !ts_valid))
        else report_value_error("busy or ts_valid high before any rd_req");

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge aclk);
    endtask

    task automatic load_time(input logic [SEC_W-1:0] sec, input logic [USEC_W-1:0] usec);
        set_sec  = sec;
        set_usec = usec;
        set_time = 1'b1;
        @(negedge aclk);
        set_time = 1'b0;
    endtask

    task automatic pulse_capture();
        capture = 1'b1;
        @(negedge aclk);
        capture = 1'b0;
    endtask

    // in_transfer set when the request overlaps a running snapshot transfer
    task automatic read_and_check(input bit extra_req, input bit in_transfer);
        int lat;
        lat      = 0;
        rd_req   = 1'b1;
        req_seen = 1'b1;
        do begin
            @(negedge aclk);
            lat++;
            rd_req = extra_req && (lat == 5);                    // second request mid-window
            assert (busy) else report_value_error("busy low inside the read window");
            if (lat > TMO) begin
                report_timeout("ts_valid");
            end
        end while (!ts_valid);
        rd_req   = 1'b0;
        got_sec  = ts_sec;
        got_usec = ts_usec;
        assert (ts_sec == newest_sec)
            else report_value_error($sformatf("ts_sec %0d, expected %0d", ts_sec, newest_sec));
        assert (ts_usec == newest_usec)
            else report_value_error($sformatf("ts_usec %0d, expected %0d", ts_usec, newest_usec));
        if (in_transfer) begin
            assert (lat > READ_LAT)
                else report_value_error($sformatf("latency %0d, expected above 13", lat));
        end else begin
            assert (lat == READ_LAT)
                else report_value_error($sformatf("latency %0d, expected 13", lat));
        end
        @(negedge aclk);
        assert (!busy) else report_value_error("busy still high after ts_valid");
        if (extra_req) begin
            repeat (2 * READ_LAT) begin
                @(negedge aclk);
                assert (!ts_valid) else report_value_error("second rd_req gave a second ts_valid");
            end
        end
    endtask

    initial begin
        void'($urandom(13));                   // one seed for the whole run
        aclk     = 1'b0;
        rrst     = 1'b1;
        set_time = 1'b0;
        set_sec  = '0;
        set_usec = '0;
        capture  = 1'b0;
        rd_req   = 1'b0;
        req_seen = 1'b0;
        repeat (5) @(negedge aclk);
        rrst = 1'b0;

        idle_cycles(20);                       // quiet period, watched by quiet_before_req

        // random load, random gap, then a snapshot
        load_time($urandom, USEC_W'($urandom % USEC_PER_SEC));
        idle_cycles(1 + $urandom % 50);
        pulse_capture();
        idle_cycles(SER_LEN + 2);
        read_and_check(1'b0, 1'b0);

        // load just under a second boundary
        load_time($urandom, USEC_W'(USEC_PER_SEC - 1 - $urandom % 3));
        keep_sec = set_sec;
        idle_cycles(16 + $urandom % 40);       // at least 4 usec, so usec wraps
        pulse_capture();
        idle_cycles(SER_LEN + 2);
        read_and_check(1'b0, 1'b0);
        assert (got_sec == keep_sec + 1 && got_usec < 20)
            else report_value_error("usec rollover did not carry into seconds");

        // exact latency with a second rd_req inside the window
        pulse_capture();
        idle_cycles(SER_LEN + 2);
        read_and_check(1'b1, 1'b0);

        // two captures, the read returns the second
        pulse_capture();
        keep_sec  = newest_sec;
        keep_usec = newest_usec;
        idle_cycles(SER_LEN + 3 + $urandom % 20);
        pulse_capture();
        idle_cycles(SER_LEN + 2);
        read_and_check(1'b0, 1'b0);
        assert (got_sec != keep_sec || got_usec != keep_usec)
            else report_value_error("read returned the first of two snapshots");
        keep_sec  = got_sec;
        keep_usec = got_usec;
        idle_cycles(1 + $urandom % 10);
        read_and_check(1'b0, 1'b0);            // no new capture
        assert (got_sec == keep_sec && got_usec == keep_usec)
            else report_value_error("repeated read changed the snapshot");

        // capture during a running transfer is dropped
        pulse_capture();
        keep_sec  = newest_sec;
        keep_usec = newest_usec;
        idle_cycles(3);
        pulse_capture();                       // serializer still sending
        idle_cycles(SER_LEN + 2);
        read_and_check(1'b0, 1'b0);
        assert (got_sec == keep_sec && got_usec == keep_usec)
            else report_value_error("capture during a transfer was not ignored");

        // rd_req while the snapshot is still in flight
        idle_cycles(5);
        pulse_capture();
        idle_cycles(1);
        read_and_check(1'b0, 1'b1);

        idle_cycles(10);
        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== hdl/rtc_counter.sv ====
`timescale 1ns/1ps

module rtc_counter #(
    parameter int CLK_PER_USEC = 100                   // aclk cycles per microsecond
) (
    input  logic                      aclk,
    input  logic                      rrst,
    input  logic                      set_time,        // load pulse
    input  logic [ts_pkg::SEC_W-1:0]  set_sec,
    input  logic [ts_pkg::USEC_W-1:0] set_usec,
    output logic [ts_pkg::SEC_W-1:0]  rtc_sec,
    output logic [ts_pkg::USEC_W-1:0] rtc_usec
);
    import ts_pkg::*;

    // prescaler needs at least one bit even for CLK_PER_USEC of 1
    localparam int PRE_W = (CLK_PER_USEC > 1) ? $clog2(CLK_PER_USEC) : 1;

    localparam logic [PRE_W-1:0]  PRE_LAST  = PRE_W'(CLK_PER_USEC - 1);
    localparam logic [USEC_W-1:0] USEC_LAST = USEC_W'(USEC_PER_SEC - 1);

    logic [PRE_W-1:0] presc;                           // aclk cycles within current usec
    logic             usec_tick;                       // last cycle of a microsecond
    logic             usec_wrap;                       // tick that rolls into next second

    assign usec_tick = (presc == PRE_LAST);
    assign usec_wrap = usec_tick && (rtc_usec == USEC_LAST);

    // prescaler, restarted by a load so the first tick is a full usec later
    always_ff @(posedge aclk) begin
        if (rrst || set_time) begin
            presc <= '0;
        end else if (usec_tick) begin
            presc <= '0;                               // wrap every CLK_PER_USEC
        end else begin
            presc <= presc + 1'b1;
        end
    end

    // microseconds field
    always_ff @(posedge aclk) begin
        if (rrst) begin
            rtc_usec <= '0;
        end else if (set_time) begin
            rtc_usec <= set_usec;                      // direct load
        end else if (usec_wrap) begin
            rtc_usec <= '0;                            // 999999 -> 0
        end else if (usec_tick) begin
            rtc_usec <= rtc_usec + 1'b1;
        end
    end

    // seconds field, only moves on a microsecond wrap
    always_ff @(posedge aclk) begin
        if (rrst) begin
            rtc_sec <= '0;
        end else if (set_time) begin
            rtc_sec <= set_sec;
        end else if (usec_wrap) begin
            rtc_sec <= rtc_sec + 1'b1;                 // carry from usec
        end
    end

endmodule

// ==== hdl/timestamp_fifo.sv ====
`timescale 1ns/1ps

module timestamp_fifo (
    input  logic                      aclk,
    input  logic                      rrst,
    input  logic                      pre_stb,         // marks the cycle before byte 0
    input  logic [ts_pkg::BYTE_W-1:0] din,             // valid for 8 cycles after pre_stb
    input  logic                      advance,         // rising edge picks the read page
    input  logic                      rstb,            // read start
    output logic [ts_pkg::BYTE_W-1:0] dout             // bytes 0..7 after rstb
);
    import ts_pkg::*;

    localparam int         DEPTH    = 2 * TS_BYTES;    // two pages of one snapshot
    localparam logic [2:0] SND_STOP = 3'(TS_BYTES - 2); // last count with snd set

    logic [BYTE_W-1:0] mem [DEPTH];                    // 16x8 buffer
    logic [3:0]        wr_ptr;                         // msb is the write page
    logic              rcv;                            // burst being written
    logic              advance_d;                      // edge detect stage
    logic              rd_page;                        // page handed to the reader
    logic [2:0]        rd_cnt;                         // byte within read page
    logic              snd;                            // readout running
    logic              snd_d;                          // covers the last byte

    // write side
    always_ff @(posedge aclk) begin
        if (rrst) begin
            rcv <= 1'b0;
        end else if (pre_stb) begin
            rcv <= 1'b1;
        end else if (wr_ptr[2:0] == 3'(TS_BYTES - 1)) begin
            rcv <= 1'b0;                               // byte 7 written this edge
        end
    end

    always_ff @(posedge aclk) begin
        if (rrst) begin
            wr_ptr <= '0;
        end else if (!rcv) begin
            wr_ptr <= {wr_ptr[3], 3'b000};             // hold page, rewind offset
        end else begin
            wr_ptr <= wr_ptr + 1'b1;                   // carry out flips the page
        end
    end

    always_ff @(posedge aclk) begin
        if (rcv) begin
            mem[wr_ptr] <= din;
        end
    end

    // page switch on the leading edge of advance
    always_ff @(posedge aclk) begin
        if (rrst) begin
            advance_d <= 1'b0;
            rd_page   <= 1'b0;
        end else begin
            advance_d <= advance;
            if (advance && !advance_d) begin
                rd_page <= ~wr_ptr[3];                 // page finished last
            end
        end
    end

    // read side, 8 bytes starting the cycle after rstb
    always_ff @(posedge aclk) begin
        if (rrst) begin
            snd    <= 1'b0;
            snd_d  <= 1'b0;
            rd_cnt <= '0;
        end else begin
            snd_d <= snd;
            if (rstb) begin
                snd <= 1'b1;
            end else if (rd_cnt == SND_STOP) begin
                snd <= 1'b0;                           // snd_d finishes byte 7
            end
            if (!snd && !rstb) begin
                rd_cnt <= '0;
            end else begin
                rd_cnt <= rd_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (rstb || snd || snd_d) begin
            dout <= mem[{rd_page, rd_cnt}];
        end
    end

endmodule

// ==== hdl/ts_capture_top.sv ====
`timescale 1ns/1ps

module ts_capture_top #(
    parameter int CLK_PER_USEC = 100                   // aclk cycles per microsecond
) (
    input  logic                      aclk,
    input  logic                      rrst,
    input  logic                      set_time,        // load the real-time counter
    input  logic [ts_pkg::SEC_W-1:0]  set_sec,
    input  logic [ts_pkg::USEC_W-1:0] set_usec,
    input  logic                      capture,         // take a snapshot
    input  logic                      rd_req,          // fetch newest snapshot
    output logic [ts_pkg::SEC_W-1:0]  ts_sec,
    output logic [ts_pkg::USEC_W-1:0] ts_usec,
    output logic                      ts_valid,
    output logic                      busy
);
    import ts_pkg::*;

    logic [SEC_W-1:0]  rtc_sec;                        // live counter
    logic [USEC_W-1:0] rtc_usec;
    logic              pre_stb;                        // serializer to fifo
    logic [BYTE_W-1:0] din;
    logic              ser_busy;                       // serializer to read controller
    logic              advance;                        // read controller to fifo
    logic              rstb;
    logic [BYTE_W-1:0] dout;                           // fifo to read controller

    rtc_counter #(
        .CLK_PER_USEC (CLK_PER_USEC)
    ) rtc_counter_i (
        .aclk     (aclk),
        .rrst     (rrst),
        .set_time (set_time),
        .set_sec  (set_sec),
        .set_usec (set_usec),
        .rtc_sec  (rtc_sec),
        .rtc_usec (rtc_usec)
    );

    ts_serializer ts_serializer_i (
        .aclk     (aclk),
        .rrst     (rrst),
        .capture  (capture),
        .rtc_sec  (rtc_sec),
        .rtc_usec (rtc_usec),
        .pre_stb  (pre_stb),
        .din      (din),
        .ser_busy (ser_busy)
    );

    timestamp_fifo timestamp_fifo_i (
        .aclk    (aclk),
        .rrst    (rrst),
        .pre_stb (pre_stb),
        .din     (din),
        .advance (advance),
        .rstb    (rstb),
        .dout    (dout)
    );

    ts_read_ctrl ts_read_ctrl_i (
        .aclk     (aclk),
        .rrst     (rrst),
        .rd_req   (rd_req),
        .ser_busy (ser_busy),
        .dout     (dout),
        .advance  (advance),
        .rstb     (rstb),
        .ts_sec   (ts_sec),
        .ts_usec  (ts_usec),
        .ts_valid (ts_valid),
        .busy     (busy)
    );

endmodule

// ==== hdl/ts_pkg.sv ====
package ts_pkg;

    // timestamp field widths
    localparam int SEC_W  = 32;            // seconds
    localparam int USEC_W = 20;            // microseconds, enough for 999999

    // byte transport
    localparam int BYTE_W   = 8;           // byte bus width
    localparam int TS_BYTES = 8;           // s0..s3 then u0..u3, lsb first

    // microsecond field wraps here and carries into seconds
    localparam int USEC_PER_SEC = 1_000_000;

    // read controller states
    typedef enum logic [2:0] {
        IDLE,                              // waiting for rd_req
        ADVANCE,                           // one cycle of advance to the fifo
        WAIT_SER,                          // hold off while a snapshot is in flight
        READ,                              // rstb issued, bytes shifting in
        DONE                               // result on ts_sec/ts_usec, ts_valid high
    } rd_state_t;

endpackage

// ==== hdl/ts_read_ctrl.sv ====
`timescale 1ns/1ps

module ts_read_ctrl (
    input  logic                      aclk,
    input  logic                      rrst,
    input  logic                      rd_req,          // read request pulse
    input  logic                      ser_busy,        // snapshot still being written
    input  logic [ts_pkg::BYTE_W-1:0] dout,            // bytes from the fifo
    output logic                      advance,         // one-cycle level to the fifo
    output logic                      rstb,            // fifo read start
    output logic [ts_pkg::SEC_W-1:0]  ts_sec,
    output logic [ts_pkg::USEC_W-1:0] ts_usec,
    output logic                      ts_valid,        // result strobe
    output logic                      busy
);
    import ts_pkg::*;

    localparam int         ASM_W      = TS_BYTES * BYTE_W;        // 64 bit assembly
    localparam int         USEC_LSB   = (TS_BYTES / 2) * BYTE_W;  // u0 position
    localparam logic [3:0] RSTB_CNT   = 4'd0;                     // cycle that arms rstb
    localparam logic [3:0] FIRST_BYTE = 4'd2;                     // byte 0 on dout here
    localparam logic [3:0] LAST_CNT   = 4'(TS_BYTES + 1);         // byte 7 on dout here

    rd_state_t        state;
    rd_state_t        state_nxt;
    logic [3:0]       rd_cnt;                          // cycles spent in READ
    logic [ASM_W-1:0] asm_r;                           // bytes shifted in lsb first
    logic             take_byte;                       // dout holds a valid byte

    // state register
    always_ff @(posedge aclk) begin
        if (rrst) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // next state
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (rd_req) begin
                    state_nxt = WAIT_SER;
                end
            end
            WAIT_SER: begin
                if (!ser_busy) begin
                    state_nxt = ADVANCE;               // newest page is complete
                end
            end
            ADVANCE: begin
                state_nxt = READ;
            end
            READ: begin
                if (rd_cnt == LAST_CNT) begin
                    state_nxt = DONE;
                end
            end
            DONE: begin
                state_nxt = IDLE;
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    // read phase counter
    always_ff @(posedge aclk) begin
        if (rrst) begin
            rd_cnt <= '0;
        end else if (state != READ) begin
            rd_cnt <= '0;
        end else begin
            rd_cnt <= rd_cnt + 1'b1;
        end
    end

    // registered read strobe, high in the second READ cycle
    always_ff @(posedge aclk) begin
        if (rrst) begin
            rstb <= 1'b0;
        end else begin
            rstb <= (state == READ) && (rd_cnt == RSTB_CNT);
        end
    end

    assign take_byte = (state == READ) && (rd_cnt >= FIRST_BYTE);

    // byte assembly, first byte ends up at the bottom
    always_ff @(posedge aclk) begin
        if (take_byte) begin
            asm_r <= {dout, asm_r[ASM_W-1:BYTE_W]};
        end
    end

    assign ts_sec   = asm_r[SEC_W-1:0];
    assign ts_usec  = asm_r[USEC_LSB +: USEC_W];        // drop zero padding
    assign advance  = (state == ADVANCE);
    assign ts_valid = (state == DONE);
    assign busy     = (state != IDLE);                 // covers rd_req+1 .. ts_valid

endmodule

// ==== hdl/ts_serializer.sv ====
`timescale 1ns/1ps

module ts_serializer (
    input  logic                      aclk,
    input  logic                      rrst,
    input  logic                      capture,         // snapshot request pulse
    input  logic [ts_pkg::SEC_W-1:0]  rtc_sec,
    input  logic [ts_pkg::USEC_W-1:0] rtc_usec,
    output logic                      pre_stb,         // one cycle before first byte
    output logic [ts_pkg::BYTE_W-1:0] din,             // byte stream to the fifo
    output logic                      ser_busy         // pre_stb plus eight byte cycles
);
    import ts_pkg::*;

    localparam int         SHD_W    = TS_BYTES * BYTE_W;   // 64 bit snapshot
    localparam int         FIELD_W  = SHD_W / 2;           // each field padded to 32
    localparam logic [3:0] IDX_IDLE = 4'(TS_BYTES);        // index parked past last byte

    logic [SHD_W-1:0] shadow;                          // latched counter value
    logic [3:0]       byte_idx;                        // byte on din, IDX_IDLE when idle
    logic             sending;                         // byte phase of the transfer
    logic             cap_ok;                          // capture accepted this cycle

    assign sending  = (byte_idx != IDX_IDLE);
    assign ser_busy = pre_stb | sending;
    assign cap_ok   = capture & ~ser_busy;             // drop captures mid-transfer

    // byte select, low index bits only since TS_BYTES is 8
    assign din = shadow[byte_idx[2:0]*BYTE_W +: BYTE_W];

    // snapshot register, seconds in the low half and usec zero-extended above
    always_ff @(posedge aclk) begin
        if (cap_ok) begin
            shadow <= {FIELD_W'(rtc_usec), FIELD_W'(rtc_sec)};
        end
    end

    // pre_stb follows an accepted capture by one cycle
    always_ff @(posedge aclk) begin
        if (rrst) begin
            pre_stb <= 1'b0;
        end else begin
            pre_stb <= cap_ok;
        end
    end

    // byte index runs 0..7 right after pre_stb, then parks
    always_ff @(posedge aclk) begin
        if (rrst) begin
            byte_idx <= IDX_IDLE;
        end else if (pre_stb) begin
            byte_idx <= '0;                            // s0 goes out next cycle
        end else if (sending) begin
            byte_idx <= byte_idx + 1'b1;               // 7 + 1 lands on IDX_IDLE
        end
    end

endmodule

// ==== list.f ====
hdl/ts_pkg.sv
hdl/rtc_counter.sv
hdl/ts_serializer.sv
hdl/timestamp_fifo.sv
hdl/ts_read_ctrl.sv
hdl/ts_capture_top.sv
dv/ts_capture_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the timestamp capture testbench with Verilator.
set -e
cd "$(dirname "$0")"

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module ts_capture_tb -o ts_capture_sim -f list.f

# keep going after a failing simulation so the log decides
./obj_dir/ts_capture_sim 2>&1 | tee "$LOG"

if grep -q "TEST FAIL" "$LOG"; then
    echo "simulation reported a failure"
    exit 1
fi
if ! grep -q "TEST PASS" "$LOG"; then
    echo "simulation ended without a pass message"
    exit 1
fi
echo "simulation passed"
